// File: test/video_bus_stim.txt
// kind addr data: kind 0 writes data to addr, kind 1 checks every pixel of frame addr
// Frame buffer words hold four palette indices, byte 0 is the leftmost pixel
0 00000000 0a0b0c0d
0 00000004 0f0e0d0c
0 00000008 01000302
0 0000000c 05040706
0 00000000 00010203
0 00000004 04050607
0 01000000 00000000
0 01000004 00ff0000
0 01000008 0000ff00
0 0100000c 000000ff
0 01000010 00ffff00
0 01000014 00ff00ff
0 01000018 0000ffff
0 0100001c 00ffffff
1 00000002 00000000
0 01000008 00123456
1 00000003 00000000
0 00000008 06060606
1 00000004 00000000

// File: vlog.f
hw/video_bus_pkg.sv
hw/mem_port_if.sv
hw/cpu_write_port.sv
hw/write_fifo.sv
hw/pixel_timer.sv
hw/vram_arbiter.sv
hw/palette_lookup.sv
hw/video_bus_top.sv
test/tb_video_bus.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_video_bus -f vlog.f \
	&& ./obj_dir/Vtb_video_bus > sim.log 2>&1 \
	|| echo "Build or simulation error"
cat sim.log 2>/dev/null
grep -q "Verification passed" sim.log && exit 0 || exit 1

// File: test/tb_video_bus.sv
`timescale 1ns/100ps

module tb_video_bus;

	localparam int H_ACTIVE = 8;
	localparam int H_TOTAL = 12;
	localparam int V_ACTIVE = 2;
	localparam int V_TOTAL = 3;
	localparam int PIX_DIV = 8;
	localparam int FIFO_DEPTH = 4;
	localparam int STIM_WORDS = 96;

	logic i_clock;
	logic i_rst;
	logic i_awvalid;
	logic o_awready;
	logic [31:0] i_awaddr;
	logic i_wvalid;
	logic o_wready;
	logic [31:0] i_wdata;
	logic o_bvalid;
	logic i_bready;
	logic [1:0] o_bresp;
	logic o_mem_request;
	logic o_mem_rw;
	logic [31:0] o_mem_address;
	logic [31:0] o_mem_wdata;
	logic [31:0] i_mem_rdata;
	logic i_mem_ready;
	logic [31:0] o_pixel;
	logic o_pixel_valid;
	logic [$clog2(H_TOTAL)-1:0] o_pos_x;
	logic [$clog2(V_TOTAL)-1:0] o_pos_y;

	logic [31:0] stim [STIM_WORDS];
	logic [31:0] vram [256];
	logic [31:0] shadow_vram [256];
	logic [31:0] shadow_pal [256];
	// Frame buffer writes accepted by the DUT, address in the upper half
	logic [63:0] write_queue [$];
	integer seed = 32'hc791;
	int errors = 0;
	int frame_count = -1;
	int check_frame = -1;
	int pixels_checked = 0;
	int last_frame = 0;
	int max_backlog = 0;
	logic seen_first = 1'b0;
	logic hold_writes = 1'b1;
	logic awready_stalled = 1'b0;

	video_bus_top #(
		.H_ACTIVE(H_ACTIVE),
		.H_TOTAL(H_TOTAL),
		.V_ACTIVE(V_ACTIVE),
		.V_TOTAL(V_TOTAL),
		.PIX_DIV(PIX_DIV),
		.FIFO_DEPTH(FIFO_DEPTH)
	) DUT (.*);

	initial begin
		i_clock = 1'b0;
		forever #5 i_clock = ~i_clock;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// Colour of pixel (x, y) from the shadow frame buffer and palette
	function automatic logic [31:0] expected_pixel(input int x, input int y);
		int byte_addr;
		logic [31:0] word;
		logic [7:0] index;
		byte_addr = y * H_ACTIVE + x;
		word = shadow_vram[(byte_addr / 4) % 256];
		index = word[8 * (byte_addr % 4) +: 8];
		return shadow_pal[index];
	endfunction

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
		int hold;
		int waited;
		i_awaddr = addr;
		i_wdata = data;
		i_awvalid = 1'b1;
		i_wvalid = 1'b1;
		waited = 0;
		@(posedge i_clock);
		#1;
		while (!o_awready) begin
			waited++;
			// Full FIFO, let the memory take writes again
			if (waited == 4)
				hold_writes = 1'b0;
			@(posedge i_clock);
			#1;
		end
		if (waited > 0)
			awready_stalled = 1'b1;
		check_value("wready", 1, o_wready);
		i_awvalid = 1'b0;
		i_wvalid = 1'b0;
		if (addr >= video_bus_pkg::PALETTE_BASE) begin
			shadow_pal[addr[9:2]] = data;
		end else begin
			shadow_vram[addr[9:2]] = data;
			write_queue.push_back({addr, data});
			if (write_queue.size() > max_backlog)
				max_backlog = write_queue.size();
		end
		// Response must wait for bready
		hold = $unsigned($random(seed)) % 4;
		@(posedge i_clock);
		#1;
		repeat (hold) begin
			check_value("bvalid_held", 1, o_bvalid);
			@(posedge i_clock);
			#1;
		end
		check_value("bvalid", 1, o_bvalid);
		check_value("bresp", 0, o_bresp);
		i_bready = 1'b1;
		@(posedge i_clock);
		#1;
		i_bready = 1'b0;
		check_value("bvalid_cleared", 0, o_bvalid);
	endtask

	task automatic wait_drained();
		hold_writes = 1'b0;
		while (write_queue.size() != 0) begin
			@(posedge i_clock);
			#1;
		end
	endtask

	task automatic expect_frame(input int frame);
		wait_drained();
		if (frame_count >= frame) begin
			$display("Frame %0d began before its writes reached video RAM", frame);
			errors++;
		end else begin
			pixels_checked = 0;
			check_frame = frame;
			while (pixels_checked < H_ACTIVE * V_ACTIVE) begin
				@(posedge i_clock);
				#1;
			end
			check_frame = -1;
		end
	endtask

	// Video RAM with a random latency of one or two cycles
	initial begin : vram_model
		int latency;
		logic [63:0] expected;
		i_mem_ready = 1'b0;
		i_mem_rdata = '0;
		forever begin
			@(posedge i_clock);
			#1;
			if (o_mem_request === 1'b1) begin
				// Writes wait while the opening burst fills the FIFO
				while (o_mem_rw && hold_writes) begin
					@(posedge i_clock);
					#1;
				end
				latency = 1 + $unsigned($random(seed)) % 2;
				repeat (latency - 1) begin
					@(posedge i_clock);
					#1;
				end
				if (o_mem_rw) begin
					$display("%0t vram write %h data %h", $time, o_mem_address, o_mem_wdata);
					if (write_queue.size() == 0) begin
						$display("Memory write to %h was never issued by the CPU", o_mem_address);
						errors++;
					end else begin
						expected = write_queue.pop_front();
						check_value("vram_write_address", expected[63:32], o_mem_address);
						check_value("vram_write_data", expected[31:0], o_mem_wdata);
					end
					vram[o_mem_address[9:2]] = o_mem_wdata;
				end else begin
					i_mem_rdata = vram[o_mem_address[9:2]];
				end
				i_mem_ready = 1'b1;
				@(posedge i_clock);
				#1;
				i_mem_ready = 1'b0;
			end
		end
	end

	initial begin : pixel_monitor
		forever begin
			@(negedge i_clock);
			if (o_pixel_valid === 1'b1) begin
				if (!seen_first) begin
					check_value("first_pixel_x", 0, o_pos_x);
					check_value("first_pixel_y", 0, o_pos_y);
					seen_first = 1'b1;
				end
				if (o_pos_x == 0 && o_pos_y == 0)
					frame_count++;
				if (frame_count == check_frame) begin
					check_value($sformatf("pixel_f%0d_x%0d_y%0d", frame_count, o_pos_x, o_pos_y),
						expected_pixel(o_pos_x, o_pos_y), o_pixel);
					pixels_checked++;
				end
			end
		end
	end

	initial begin : stimulus
		int rec;
		// Words past the end of the file keep an all-ones end marker
		for (rec = 0; rec < STIM_WORDS; rec++)
			stim[rec] = '1;
		$readmemh("test/video_bus_stim.txt", stim);
		for (rec = 0; rec < STIM_WORDS / 3; rec++) begin
			if (stim[3*rec] == 1 && stim[3*rec+1] > last_frame)
				last_frame = stim[3*rec+1];
		end
		for (rec = 0; rec < 256; rec++) begin
			vram[rec] = {8'(rec), 8'(~rec), 8'(rec * 7), 8'(rec ^ 8'ha5)};
			shadow_vram[rec] = vram[rec];
		end
		i_rst = 1'b1;
		i_awvalid = 1'b0;
		i_wvalid = 1'b0;
		i_awaddr = '0;
		i_wdata = '0;
		i_bready = 1'b0;
		repeat (8) @(posedge i_clock);
		#1;
		i_rst = 1'b0;
		check_value("reset_awready", 0, o_awready);
		check_value("reset_bvalid", 0, o_bvalid);
		check_value("reset_mem_request", 0, o_mem_request);
		check_value("reset_pixel_valid", 0, o_pixel_valid);
		rec = 0;
		while (rec < STIM_WORDS / 3 && stim[3*rec] <= 1) begin
			if (stim[3*rec] == 0)
				axi_write(stim[3*rec+1], stim[3*rec+2]);
			else
				expect_frame(stim[3*rec+1]);
			rec++;
		end
		wait_drained();
		check_value("awready_stalled", 1, awready_stalled);
		check_value("burst_within_fifo", 1, max_backlog <= FIFO_DEPTH);
		check_value("first_pixel_seen", 1, seen_first);
		$display("Checks done with %0d errors", errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// Limit is the last checked frame plus two, in whole frames
	initial begin : watchdog
		#1;
		#((last_frame + 2) * V_TOTAL * H_TOTAL * PIX_DIV * 10);
		$display("Watchdog expired before the stimulus completed");
		$display("Checks done with %0d errors", errors);
		$display("Verification failed");
		$finish;
	end

endmodule

// File: hw/video_bus_top.sv
`timescale 1ns/100ps

module video_bus_top #(
	parameter int H_ACTIVE = 320,
	parameter int H_TOTAL = 400,
	parameter int V_ACTIVE = 240,
	parameter int V_TOTAL = 262,
	parameter int PIX_DIV = 8,
	parameter int FIFO_DEPTH = 16
) (
	input logic i_clock,
	input logic i_rst,
	input logic i_awvalid,
	output logic o_awready,
	input logic [video_bus_pkg::ADDR_W-1:0] i_awaddr,
	input logic i_wvalid,
	output logic o_wready,
	input logic [video_bus_pkg::DATA_W-1:0] i_wdata,
	output logic o_bvalid,
	input logic i_bready,
	output logic [1:0] o_bresp,
	output logic o_mem_request,
	output logic o_mem_rw,
	output logic [video_bus_pkg::ADDR_W-1:0] o_mem_address,
	output logic [video_bus_pkg::DATA_W-1:0] o_mem_wdata,
	input logic [video_bus_pkg::DATA_W-1:0] i_mem_rdata,
	input logic i_mem_ready,
	output logic [video_bus_pkg::DATA_W-1:0] o_pixel,
	output logic o_pixel_valid,
	output logic [$clog2(H_TOTAL)-1:0] o_pos_x,
	output logic [$clog2(V_TOTAL)-1:0] o_pos_y
);

	logic fifo_push;
	logic fifo_pop;
	logic fifo_empty;
	logic fifo_full;
	video_bus_pkg::fifo_entry_t push_entry;
	video_bus_pkg::fifo_entry_t fifo_head;
	logic pal_we;
	logic [7:0] pal_index;
	logic [video_bus_pkg::DATA_W-1:0] pal_data;
	logic pix_tick;
	logic active;
	logic [$clog2(H_TOTAL)-1:0] pos_x;
	logic [$clog2(V_TOTAL)-1:0] pos_y;
	logic fetch;
	logic [video_bus_pkg::ADDR_W-1:0] fetch_addr;
	logic quad_valid;
	logic [video_bus_pkg::DATA_W-1:0] quad;

	mem_port_if mem ();

	assign o_mem_request = mem.request;
	assign o_mem_rw = mem.rw;
	assign o_mem_address = mem.address;
	assign o_mem_wdata = mem.wdata;
	assign mem.rdata = i_mem_rdata;
	assign mem.ready = i_mem_ready;

	cpu_write_port u_cpu_write_port (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_awvalid(i_awvalid),
		.o_awready(o_awready),
		.i_awaddr(i_awaddr),
		.i_wvalid(i_wvalid),
		.o_wready(o_wready),
		.i_wdata(i_wdata),
		.o_bvalid(o_bvalid),
		.i_bready(i_bready),
		.o_bresp(o_bresp),
		.i_fifo_full(fifo_full),
		.o_push(fifo_push),
		.o_push_entry(push_entry),
		.o_pal_we(pal_we),
		.o_pal_index(pal_index),
		.o_pal_data(pal_data)
	);

	write_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_write_fifo (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_push(fifo_push),
		.i_entry(push_entry),
		.i_pop(fifo_pop),
		.o_head(fifo_head),
		.o_empty(fifo_empty),
		.o_full(fifo_full)
	);

	pixel_timer #(
		.H_ACTIVE(H_ACTIVE),
		.H_TOTAL(H_TOTAL),
		.V_ACTIVE(V_ACTIVE),
		.V_TOTAL(V_TOTAL),
		.PIX_DIV(PIX_DIV)
	) u_pixel_timer (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.o_pix_tick(pix_tick),
		.o_pos_x(pos_x),
		.o_pos_y(pos_y),
		.o_active(active),
		.o_fetch(fetch),
		.o_fetch_addr(fetch_addr)
	);

	vram_arbiter u_vram_arbiter (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_fetch(fetch),
		.i_fetch_addr(fetch_addr),
		.i_fifo_head(fifo_head),
		.i_fifo_empty(fifo_empty),
		.o_fifo_pop(fifo_pop),
		.mem(mem.master),
		.o_quad_valid(quad_valid),
		.o_quad(quad)
	);

	palette_lookup u_palette_lookup (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_pal_we(pal_we),
		.i_pal_index(pal_index),
		.i_pal_data(pal_data),
		.i_quad_valid(quad_valid),
		.i_quad(quad),
		.i_pix_tick(pix_tick),
		.i_pos_x(pos_x[1:0]),
		.i_active(active),
		.o_pixel(o_pixel),
		.o_pixel_valid(o_pixel_valid)
	);

	// Position travels with the pixel colour
	always_ff @(posedge i_clock) begin
		if (pix_tick) begin
			o_pos_x <= pos_x;
			o_pos_y <= pos_y;
		end
	end

endmodule

// File: hw/palette_lookup.sv
`timescale 1ns/100ps

module palette_lookup (
	input logic i_clock,
	input logic i_rst,
	input logic i_pal_we,
	input logic [7:0] i_pal_index,
	input logic [video_bus_pkg::DATA_W-1:0] i_pal_data,
	input logic i_quad_valid,
	input logic [video_bus_pkg::DATA_W-1:0] i_quad,
	input logic i_pix_tick,
	input logic [1:0] i_pos_x,
	input logic i_active,
	output logic [video_bus_pkg::DATA_W-1:0] o_pixel,
	output logic o_pixel_valid
);

	logic [video_bus_pkg::DATA_W-1:0] palette [256];
	logic [video_bus_pkg::DATA_W-1:0] next_quad;
	logic [video_bus_pkg::DATA_W-1:0] cur_quad;
	logic [video_bus_pkg::DATA_W-1:0] sel_quad;
	logic [7:0] index;

	always_ff @(posedge i_clock) begin
		if (i_pal_we)
			palette[i_pal_index] <= i_pal_data;
	end

	// On a boundary tick the staged quad is the one in use
	assign sel_quad = (i_pos_x == 2'b00) ? next_quad : cur_quad;
	assign index = sel_quad[8*i_pos_x +: 8];

	always_ff @(posedge i_clock) begin
		if (i_quad_valid)
			next_quad <= i_quad;
		if (i_pix_tick && i_pos_x == 2'b00)
			cur_quad <= next_quad;
		if (i_pix_tick)
			o_pixel <= palette[index];
	end

	always_ff @(posedge i_clock) begin
		if (i_rst)
			o_pixel_valid <= 1'b0;
		else
			o_pixel_valid <= i_pix_tick && i_active;
	end

endmodule

// File: hw/vram_arbiter.sv
`timescale 1ns/100ps

module vram_arbiter (
	input logic i_clock,
	input logic i_rst,
	input logic i_fetch,
	input logic [video_bus_pkg::ADDR_W-1:0] i_fetch_addr,
	input video_bus_pkg::fifo_entry_t i_fifo_head,
	input logic i_fifo_empty,
	output logic o_fifo_pop,
	mem_port_if.master mem,
	output logic o_quad_valid,
	output logic [video_bus_pkg::DATA_W-1:0] o_quad
);

	video_bus_pkg::arb_state_t state;
	logic fetch_pending;
	logic [video_bus_pkg::ADDR_W-1:0] pending_addr;

	// Head leaves the FIFO once the write is taken
	assign o_fifo_pop = (state == video_bus_pkg::DRAIN) && mem.ready;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= video_bus_pkg::IDLE;
			mem.request <= 1'b0;
			fetch_pending <= 1'b0;
			o_quad_valid <= 1'b0;
		end else begin
			o_quad_valid <= 1'b0;
			// Strobe may land mid drain, keep it for later
			if (i_fetch)
				fetch_pending <= 1'b1;

			case (state)
				video_bus_pkg::IDLE: begin
					if (fetch_pending || i_fetch) begin
						state <= video_bus_pkg::FETCH;
						mem.request <= 1'b1;
						fetch_pending <= 1'b0;
					end else if (!i_fifo_empty) begin
						state <= video_bus_pkg::DRAIN;
						mem.request <= 1'b1;
					end
				end
				video_bus_pkg::DRAIN: begin
					if (mem.ready) begin
						state <= video_bus_pkg::IDLE;
						mem.request <= 1'b0;
					end
				end
				video_bus_pkg::FETCH: begin
					if (mem.ready) begin
						state <= video_bus_pkg::HOLD;
						mem.request <= 1'b0;
						o_quad_valid <= 1'b1;
					end
				end
				default: begin
					state <= video_bus_pkg::IDLE;
				end
			endcase
		end
	end

	// Request fields, loaded only when a transaction starts
	always_ff @(posedge i_clock) begin
		if (i_fetch)
			pending_addr <= i_fetch_addr;
		if (state == video_bus_pkg::IDLE) begin
			if (fetch_pending || i_fetch) begin
				mem.rw <= 1'b0;
				mem.address <= i_fetch ? i_fetch_addr : pending_addr;
			end else if (!i_fifo_empty) begin
				mem.rw <= 1'b1;
				mem.address <= i_fifo_head.address;
				mem.wdata <= i_fifo_head.data;
			end
		end
		if (state == video_bus_pkg::FETCH && mem.ready)
			o_quad <= mem.rdata;
	end

endmodule

// File: hw/pixel_timer.sv
`timescale 1ns/100ps

module pixel_timer #(
	parameter int H_ACTIVE = 320,
	parameter int H_TOTAL = 400,
	parameter int V_ACTIVE = 240,
	parameter int V_TOTAL = 262,
	parameter int PIX_DIV = 8
) (
	input logic i_clock,
	input logic i_rst,
	output logic o_pix_tick,
	output logic [$clog2(H_TOTAL)-1:0] o_pos_x,
	output logic [$clog2(V_TOTAL)-1:0] o_pos_y,
	output logic o_active,
	output logic o_fetch,
	output logic [video_bus_pkg::ADDR_W-1:0] o_fetch_addr
);

	localparam int X_W = $clog2(H_TOTAL);
	localparam int Y_W = $clog2(V_TOTAL);
	localparam int DIV_W = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;
	localparam int AW = video_bus_pkg::ADDR_W;

	logic [DIV_W-1:0] div_cnt;
	logic [X_W:0] ahead_x;
	logic line_wrap;
	logic [Y_W-1:0] next_line;
	logic [Y_W-1:0] fetch_y;
	logic [X_W:0] fetch_x;
	logic fetch_ok;

	// Tick marks the first clock of each pixel period
	assign o_pix_tick = (div_cnt == '0);
	assign o_active = (o_pos_x < H_ACTIVE) && (o_pos_y < V_ACTIVE);

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			div_cnt <= '0;
			o_pos_x <= '0;
			o_pos_y <= '0;
		end else if (div_cnt == DIV_W'(PIX_DIV - 1)) begin
			div_cnt <= '0;
			if (o_pos_x == X_W'(H_TOTAL - 1)) begin
				o_pos_x <= '0;
				o_pos_y <= next_line;
			end else begin
				o_pos_x <= o_pos_x + 1'b1;
			end
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Quad two pixels ahead, possibly on the next line or frame
	always_comb begin
		ahead_x = {1'b0, o_pos_x} + (X_W + 1)'(2);
		line_wrap = (o_pos_x == X_W'(H_TOTAL - 2));
		next_line = (o_pos_y == Y_W'(V_TOTAL - 1)) ? '0 : o_pos_y + 1'b1;
		fetch_y = line_wrap ? next_line : o_pos_y;
		fetch_x = line_wrap ? '0 : ahead_x;
		if (line_wrap)
			fetch_ok = (next_line < V_ACTIVE);
		else
			fetch_ok = (ahead_x[1:0] == 2'b00) && (ahead_x < H_ACTIVE) && (o_pos_y < V_ACTIVE);
	end

	assign o_fetch = o_pix_tick && fetch_ok;
	assign o_fetch_addr = AW'(fetch_y) * AW'(H_ACTIVE) + AW'(fetch_x);

endmodule

// File: hw/write_fifo.sv
`timescale 1ns/100ps

module write_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input logic i_clock,
	input logic i_rst,
	input logic i_push,
	input video_bus_pkg::fifo_entry_t i_entry,
	input logic i_pop,
	output video_bus_pkg::fifo_entry_t o_head,
	output logic o_empty,
	output logic o_full
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	video_bus_pkg::fifo_entry_t store [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = i_push && !o_full;
	assign do_pop = i_pop && !o_empty;
	assign o_empty = (count == '0);
	assign o_full = (count == CNT_W'(FIFO_DEPTH));

	// Head is read straight from the array
	assign o_head = store[rd_ptr];

	always_ff @(posedge i_clock) begin
		if (do_push)
			store[wr_ptr] <= i_entry;
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: hw/cpu_write_port.sv
`timescale 1ns/100ps

module cpu_write_port (
	input logic i_clock,
	input logic i_rst,
	input logic i_awvalid,
	output logic o_awready,
	input logic [video_bus_pkg::ADDR_W-1:0] i_awaddr,
	input logic i_wvalid,
	output logic o_wready,
	input logic [video_bus_pkg::DATA_W-1:0] i_wdata,
	output logic o_bvalid,
	input logic i_bready,
	output logic [1:0] o_bresp,
	input logic i_fifo_full,
	output logic o_push,
	output video_bus_pkg::fifo_entry_t o_push_entry,
	output logic o_pal_we,
	output logic [7:0] o_pal_index,
	output logic [video_bus_pkg::DATA_W-1:0] o_pal_data
);

	logic is_palette;
	logic accept;

	assign is_palette = (i_awaddr >= video_bus_pkg::PALETTE_BASE);

	// Both channels valid, no response outstanding, room for the write
	assign accept = i_awvalid && i_wvalid && !o_awready && !o_bvalid &&
		(is_palette || !i_fifo_full);

	assign o_bresp = video_bus_pkg::RESP_OKAY;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_awready <= 1'b0;
			o_wready <= 1'b0;
			o_bvalid <= 1'b0;
			o_push <= 1'b0;
			o_pal_we <= 1'b0;
		end else begin
			o_awready <= accept;
			o_wready <= accept;
			o_push <= accept && !is_palette;
			o_pal_we <= accept && is_palette;
			if (o_awready)
				o_bvalid <= 1'b1;
			else if (i_bready)
				o_bvalid <= 1'b0;
		end
	end

	// Captured with the decision, used in the ready cycle
	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_push_entry.address <= i_awaddr;
			o_push_entry.data <= i_wdata;
			o_pal_index <= i_awaddr[9:2];
			o_pal_data <= i_wdata;
		end
	end

endmodule

// File: hw/mem_port_if.sv
`timescale 1ns/100ps

interface mem_port_if;

	logic request;
	// High for a write, low for a read
	logic rw;
	logic [video_bus_pkg::ADDR_W-1:0] address;
	logic [video_bus_pkg::DATA_W-1:0] wdata;
	logic [video_bus_pkg::DATA_W-1:0] rdata;
	logic ready;

	modport master (
		output request,
		output rw,
		output address,
		output wdata,
		input rdata,
		input ready
	);

	modport slave (
		input request,
		input rw,
		input address,
		input wdata,
		output rdata,
		output ready
	);

endinterface

// File: hw/video_bus_pkg.sv
package video_bus_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// Byte addresses at or above this go to the palette
	localparam logic [ADDR_W-1:0] PALETTE_BASE = 32'h0100_0000;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef enum logic [1:0] {
		IDLE,
		DRAIN,
		FETCH,
		HOLD
	} arb_state_t;

	// One pending frame buffer write
	typedef struct packed {
		logic [ADDR_W-1:0] address;
		logic [DATA_W-1:0] data;
	} fifo_entry_t;

endpackage
